// File: decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flushE_i,
    input  rvTypesPkg::word_t      instrD_i,
    input  rvTypesPkg::word_t      pcD_i,
    input  rvTypesPkg::word_t      pcPlus4D_i,
    input  rvTypesPkg::word_t      rd1D_i,
    input  rvTypesPkg::word_t      rd2D_i,
    output rvTypesPkg::regAddr_t   rs1D_o,
    output rvTypesPkg::regAddr_t   rs2D_o,
    output rvTypesPkg::word_t      rd1E_o,
    output rvTypesPkg::word_t      rd2E_o,
    output rvTypesPkg::word_t      immExtE_o,
    output rvTypesPkg::word_t      pcE_o,
    output rvTypesPkg::word_t      pcPlus4E_o,
    output rvTypesPkg::regAddr_t   rs1E_o,
    output rvTypesPkg::regAddr_t   rs2E_o,
    output rvTypesPkg::regAddr_t   rdE_o,
    output rvCtrlPkg::aluOp_t      aluOpE_o,
    output logic                   aluSrcAE_o,
    output logic                   aluSrcBE_o,
    output logic                   branchE_o,
    output logic                   jumpE_o,
    output logic                   regWriteE_o,
    output logic                   memWriteE_o,
    output logic                   memReadE_o,
    output rvCtrlPkg::resultSrc_t  resultSrcE_o
);
    import rvTypesPkg::*;
    import rvCtrlPkg::*;

    opcode_t    opcodeD;
    funct3_t    funct3D;
    logic       subBitD;
    regAddr_t   rdD;
    word_t      immExtD;
    immSrc_t    immSrcD;
    aluOp_t     aluOpD;
    aluOp_t     fieldOpD; // op picked by funct3 for R and I types
    resultSrc_t resultSrcD;
    logic       regWriteD;
    logic       memWriteD;
    logic       memReadD;
    logic       branchD;
    logic       jumpD;
    logic       aluSrcAD;
    logic       aluSrcBD;

    assign opcodeD = opcode_t'(instrD_i[6:0]);
    assign funct3D = instrD_i[14:12];
    assign subBitD = instrD_i[30] & instrD_i[5]; // only R-type sub, addi never subtracts
    assign rdD     = instrD_i[11:7];
    assign rs1D_o  = instrD_i[19:15];
    assign rs2D_o  = instrD_i[24:20];

    always_comb begin
        case (funct3D)
            3'b000:  fieldOpD = subBitD ? ALU_SUB : ALU_ADD;
            3'b010:  fieldOpD = ALU_SLT;
            3'b100:  fieldOpD = ALU_XOR;
            3'b110:  fieldOpD = ALU_OR;
            3'b111:  fieldOpD = ALU_AND;
            default: fieldOpD = ALU_ADD;
        endcase
    end

    // main decoder, anything not listed becomes a bubble
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        memReadD   = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        aluSrcAD   = 1'b0;
        aluSrcBD   = 1'b0;
        resultSrcD = RES_ALU;
        immSrcD    = IMM_I;
        aluOpD     = ALU_ADD;
        case (opcodeD)
            OP_LOAD: begin
                regWriteD  = 1'b1;
                memReadD   = 1'b1;
                aluSrcBD   = 1'b1;
                resultSrcD = RES_MEM;
            end
            OP_STORE: begin
                memWriteD = 1'b1;
                aluSrcBD  = 1'b1;
                immSrcD   = IMM_S;
            end
            OP_RTYPE: begin
                regWriteD = 1'b1;
                aluOpD    = fieldOpD;
            end
            OP_ITYPE: begin
                regWriteD = 1'b1;
                aluSrcBD  = 1'b1;
                aluOpD    = fieldOpD;
            end
            OP_BRANCH: begin
                branchD = 1'b1;
                immSrcD = IMM_B;
                aluOpD  = ALU_SUB; // beq tests for a zero difference
            end
            OP_JAL: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                immSrcD    = IMM_J;
                resultSrcD = RES_PC4;
            end
            OP_LUI: begin
                regWriteD = 1'b1;
                aluSrcAD  = 1'b1; // zero plus upper immediate
                aluSrcBD  = 1'b1;
                immSrcD   = IMM_U;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (immSrcD)
            IMM_S: immExtD = {{20{instrD_i[31]}}, instrD_i[31:25], instrD_i[11:7]};
            IMM_B: immExtD = {{20{instrD_i[31]}}, instrD_i[7], instrD_i[30:25],
                              instrD_i[11:8], 1'b0};
            IMM_J: immExtD = {{12{instrD_i[31]}}, instrD_i[19:12], instrD_i[20],
                              instrD_i[30:21], 1'b0};
            IMM_U: immExtD = {instrD_i[31:12], 12'b0};
            default: immExtD = {{20{instrD_i[31]}}, instrD_i[31:20]};
        endcase
    end

    // decode to execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd1E_o       <= '0;
            rd2E_o       <= '0;
            immExtE_o    <= '0;
            pcE_o        <= '0;
            pcPlus4E_o   <= '0;
            rs1E_o       <= '0;
            rs2E_o       <= '0;
            rdE_o        <= '0;
            aluOpE_o     <= ALU_ADD;
            aluSrcAE_o   <= 1'b0;
            aluSrcBE_o   <= 1'b0;
            branchE_o    <= 1'b0;
            jumpE_o      <= 1'b0;
            regWriteE_o  <= 1'b0;
            memWriteE_o  <= 1'b0;
            memReadE_o   <= 1'b0;
            resultSrcE_o <= RES_ALU;
        end else if (flushE_i) begin
            rd1E_o       <= '0;
            rd2E_o       <= '0;
            immExtE_o    <= '0;
            pcE_o        <= '0;
            pcPlus4E_o   <= '0;
            rs1E_o       <= '0;
            rs2E_o       <= '0;
            rdE_o        <= '0;
            aluOpE_o     <= ALU_ADD;
            aluSrcAE_o   <= 1'b0;
            aluSrcBE_o   <= 1'b0;
            branchE_o    <= 1'b0;
            jumpE_o      <= 1'b0;
            regWriteE_o  <= 1'b0;
            memWriteE_o  <= 1'b0;
            memReadE_o   <= 1'b0;
            resultSrcE_o <= RES_ALU;
        end else begin
            rd1E_o       <= rd1D_i;
            rd2E_o       <= rd2D_i;
            immExtE_o    <= immExtD;
            pcE_o        <= pcD_i;
            pcPlus4E_o   <= pcPlus4D_i;
            rs1E_o       <= rs1D_o;
            rs2E_o       <= rs2D_o;
            rdE_o        <= rdD;
            aluOpE_o     <= aluOpD;
            aluSrcAE_o   <= aluSrcAD;
            aluSrcBE_o   <= aluSrcBD;
            branchE_o    <= branchD;
            jumpE_o      <= jumpD;
            regWriteE_o  <= regWriteD;
            memWriteE_o  <= memWriteD;
            memReadE_o   <= memReadD;
            resultSrcE_o <= resultSrcD;
        end
    end

endmodule

// File: executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic                  clk,
    input  logic                  reset,
    input  rvTypesPkg::word_t     rd1E_i,
    input  rvTypesPkg::word_t     rd2E_i,
    input  rvTypesPkg::word_t     immExtE_i,
    input  rvTypesPkg::word_t     pcE_i,
    input  rvTypesPkg::word_t     pcPlus4E_i,
    input  rvTypesPkg::regAddr_t  rdE_i,
    input  rvCtrlPkg::aluOp_t     aluOpE_i,
    input  logic                  aluSrcAE_i,
    input  logic                  aluSrcBE_i,
    input  logic                  branchE_i,
    input  logic                  jumpE_i,
    input  logic                  regWriteE_i,
    input  logic                  memWriteE_i,
    input  logic                  memReadE_i,
    input  rvCtrlPkg::resultSrc_t resultSrcE_i,
    input  rvCtrlPkg::fwdSel_t    forwardAE_i,
    input  rvCtrlPkg::fwdSel_t    forwardBE_i,
    input  rvTypesPkg::word_t     resultW_i,
    output logic                  pcSrcE_o,
    output rvTypesPkg::word_t     pcTargetE_o,
    output rvTypesPkg::word_t     aluResultM_o,
    output rvTypesPkg::word_t     writeDataM_o,
    output rvTypesPkg::word_t     pcPlus4M_o,
    output rvTypesPkg::regAddr_t  rdM_o,
    output logic                  regWriteM_o,
    output logic                  memWriteM_o,
    output logic                  memReadM_o,
    output rvCtrlPkg::resultSrc_t resultSrcM_o
);
    import rvTypesPkg::*;
    import rvCtrlPkg::*;

    word_t srcAFwd;
    word_t writeDataE; // forwarded rs2, also the store data
    word_t srcA;
    word_t srcB;
    word_t bOperand;
    word_t sum;
    word_t aluResultE;
    logic  subMode;
    logic  overflow;
    logic  zeroE;

    function automatic word_t pickFwd(fwdSel_t sel, word_t regVal);
        case (sel)
            FWD_WB:  return resultW_i;
            FWD_MEM: return aluResultM_o; // result sitting in the memory stage
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        srcAFwd    = pickFwd(forwardAE_i, rd1E_i);
        writeDataE = pickFwd(forwardBE_i, rd2E_i);
    end

    assign srcA       = aluSrcAE_i ? '0 : srcAFwd; // lui adds to zero
    assign srcB       = aluSrcBE_i ? immExtE_i : writeDataE;

    assign subMode  = (aluOpE_i == ALU_SUB) || (aluOpE_i == ALU_SLT);
    assign bOperand = subMode ? ~srcB : srcB;
    assign sum      = srcA + bOperand + {31'b0, subMode};
    // signs differ and result sign flipped away from a
    assign overflow = (srcA[31] ^ srcB[31]) & (srcA[31] ^ sum[31]);

    always_comb begin
        case (aluOpE_i)
            ALU_AND: aluResultE = srcA & srcB;
            ALU_OR:  aluResultE = srcA | srcB;
            ALU_XOR: aluResultE = srcA ^ srcB;
            ALU_SLT: aluResultE = {31'b0, sum[31] ^ overflow};
            default: aluResultE = sum; // add and sub
        endcase
    end

    assign zeroE       = (aluResultE == '0);
    assign pcSrcE_o    = (branchE_i & zeroE) | jumpE_i;
    assign pcTargetE_o = pcE_i + immExtE_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluResultM_o <= '0;
            writeDataM_o <= '0;
            pcPlus4M_o   <= '0;
            rdM_o        <= '0;
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            memReadM_o   <= 1'b0;
            resultSrcM_o <= RES_ALU;
        end else begin
            aluResultM_o <= aluResultE;
            writeDataM_o <= writeDataE;
            pcPlus4M_o   <= pcPlus4E_i;
            rdM_o        <= rdE_i;
            regWriteM_o  <= regWriteE_i;
            memWriteM_o  <= memWriteE_i;
            memReadM_o   <= memReadE_i;
            resultSrcM_o <= resultSrcE_i;
        end
    end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ns
`include "rvCore_cfg.svh"

module fetchStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              stallF_i,
    input  logic              stallD_i,
    input  logic              flushD_i,
    input  logic              pcSrcE_i,
    input  rvTypesPkg::word_t pcTargetE_i,
    input  rvTypesPkg::word_t instrF_i,
    output rvTypesPkg::word_t pcF_o,
    output rvTypesPkg::word_t instrD_o,
    output rvTypesPkg::word_t pcD_o,
    output rvTypesPkg::word_t pcPlus4D_o
);
    import rvTypesPkg::*;

    word_t pcPlus4F;
    word_t pcNextF;

    assign pcPlus4F = pcF_o + `RV_INSTR_STEP;
    assign pcNextF  = pcSrcE_i ? pcTargetE_i : pcPlus4F; // taken branch or jal wins

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pcF_o <= `RV_RESET_PC;
        end else if (!stallF_i) begin
            pcF_o <= pcNextF;
        end
    end

    // fetch to decode register, flush leaves an all-zero bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrD_o   <= '0;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (flushD_i) begin
            instrD_o   <= '0;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (!stallD_i) begin
            instrD_o   <= instrF_i;
            pcD_o      <= pcF_o;
            pcPlus4D_o <= pcPlus4F;
        end
    end

endmodule

// File: flist.f
+incdir+.
rvTypesPkg.sv
rvCtrlPkg.sv
fetchStage.sv
decodeStage.sv
regFile.sv
executeStage.sv
hazardUnit.sv
memWbStage.sv
rvCore.sv
tbRvCore.sv

// File: hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  rvTypesPkg::regAddr_t  rs1D_i,
    input  rvTypesPkg::regAddr_t  rs2D_i,
    input  rvTypesPkg::regAddr_t  rs1E_i,
    input  rvTypesPkg::regAddr_t  rs2E_i,
    input  rvTypesPkg::regAddr_t  rdE_i,
    input  rvTypesPkg::regAddr_t  rdM_i,
    input  rvTypesPkg::regAddr_t  rdW_i,
    input  rvCtrlPkg::resultSrc_t resultSrcE_i,
    input  logic                  pcSrcE_i,
    input  logic                  regWriteM_i,
    input  logic                  regWriteW_i,
    output rvCtrlPkg::fwdSel_t    forwardAE_o,
    output rvCtrlPkg::fwdSel_t    forwardBE_o,
    output logic                  stallF_o,
    output logic                  stallD_o,
    output logic                  flushD_o,
    output logic                  flushE_o
);
    import rvTypesPkg::*;
    import rvCtrlPkg::*;

    logic loadUseStall;

    // memory stage holds the younger result, so it wins over writeback
    function automatic fwdSel_t pickSrc(regAddr_t rs);
        if (rs == '0) begin
            return FWD_RF;
        end else if (regWriteM_i && rs == rdM_i) begin
            return FWD_MEM;
        end else if (regWriteW_i && rs == rdW_i) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        forwardAE_o = pickSrc(rs1E_i);
        forwardBE_o = pickSrc(rs2E_i);
    end

    // load in execute feeding the instruction in decode
    assign loadUseStall = (resultSrcE_i == RES_MEM) && (rdE_i != '0) &&
                          ((rs1D_i == rdE_i) || (rs2D_i == rdE_i));

    assign stallF_o = loadUseStall;
    assign stallD_o = loadUseStall;
    assign flushD_o = pcSrcE_i;
    assign flushE_o = loadUseStall | pcSrcE_i; // bubble into execute

endmodule

// File: memWbStage.sv
`timescale 1ns/1ns

module memWbStage (
    input  logic                  clk,
    input  logic                  reset,
    input  rvTypesPkg::word_t     aluResultM_i,
    input  rvTypesPkg::word_t     readData_i,
    input  rvTypesPkg::word_t     pcPlus4M_i,
    input  rvTypesPkg::regAddr_t  rdM_i,
    input  logic                  regWriteM_i,
    input  rvCtrlPkg::resultSrc_t resultSrcM_i,
    output rvTypesPkg::word_t     resultW_o,
    output rvTypesPkg::regAddr_t  rdW_o,
    output logic                  regWriteW_o
);
    import rvTypesPkg::*;
    import rvCtrlPkg::*;

    word_t      aluResultW;
    word_t      readDataW;
    word_t      pcPlus4W;
    resultSrc_t resultSrcW;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluResultW  <= '0;
            readDataW   <= '0;
            pcPlus4W    <= '0;
            rdW_o       <= '0;
            regWriteW_o <= 1'b0;
            resultSrcW  <= RES_ALU;
        end else begin
            aluResultW  <= aluResultM_i;
            readDataW   <= readData_i; // same-cycle memory read
            pcPlus4W    <= pcPlus4M_i;
            rdW_o       <= rdM_i;
            regWriteW_o <= regWriteM_i;
            resultSrcW  <= resultSrcM_i;
        end
    end

    always_comb begin
        case (resultSrcW)
            RES_MEM: resultW_o = readDataW;
            RES_PC4: resultW_o = pcPlus4W;
            default: resultW_o = aluResultW;
        endcase
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ns
`include "rvCore_cfg.svh"

module regFile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 regWrite_i,
    input  rvTypesPkg::regAddr_t rs1_i,
    input  rvTypesPkg::regAddr_t rs2_i,
    input  rvTypesPkg::regAddr_t rd_i,
    input  rvTypesPkg::word_t    wd_i,
    output rvTypesPkg::word_t    rd1_o,
    output rvTypesPkg::word_t    rd2_o
);
    import rvTypesPkg::*;

    word_t regs [`RV_NUM_REGS];

    // falling edge write so decode sees the value in the same cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite_i) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i != '0) ? regs[rs1_i] : '0; // x0 hardwired
    assign rd2_o = (rs2_i != '0) ? regs[rs2_i] : '0;

endmodule

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbRvCore -f flist.f -o simRvCore
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simRvCore > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// File: rvCore.sv
`timescale 1ns/1ns

module rvCore (
    input  logic              clk,
    input  logic              reset,
    input  rvTypesPkg::word_t instrF_i,
    input  rvTypesPkg::word_t readData_i,
    output rvTypesPkg::word_t pcF_o,
    output rvTypesPkg::word_t dataAddr_o,
    output rvTypesPkg::word_t writeData_o,
    output logic              memWrite_o,
    output logic              memRead_o
);
    import rvTypesPkg::*;
    import rvCtrlPkg::*;

    // fetch and decode
    word_t      instrD, pcD, pcPlus4D, rd1D, rd2D;
    regAddr_t   rs1D, rs2D;
    // execute
    word_t      rd1E, rd2E, immExtE, pcE, pcPlus4E, pcTargetE;
    regAddr_t   rs1E, rs2E, rdE;
    aluOp_t     aluOpE;
    resultSrc_t resultSrcE;
    logic       aluSrcAE, aluSrcBE, branchE, jumpE, regWriteE, memWriteE, memReadE;
    logic       pcSrcE;
    // memory and writeback
    word_t      aluResultM, writeDataM, pcPlus4M, resultW;
    regAddr_t   rdM, rdW;
    resultSrc_t resultSrcM;
    logic       regWriteM, memWriteM, memReadM, regWriteW;
    // hazard control
    fwdSel_t    forwardAE, forwardBE;
    logic       stallF, stallD, flushD, flushE;

    assign dataAddr_o  = aluResultM;
    assign writeData_o = writeDataM;
    assign memWrite_o  = memWriteM;
    assign memRead_o   = memReadM;

    fetchStage u_fetch (
        .clk(clk), .reset(reset),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD),
        .pcSrcE_i(pcSrcE), .pcTargetE_i(pcTargetE), .instrF_i(instrF_i),
        .pcF_o(pcF_o), .instrD_o(instrD), .pcD_o(pcD), .pcPlus4D_o(pcPlus4D)
    );

    decodeStage u_decode (
        .clk(clk), .reset(reset), .flushE_i(flushE),
        .instrD_i(instrD), .pcD_i(pcD), .pcPlus4D_i(pcPlus4D),
        .rd1D_i(rd1D), .rd2D_i(rd2D), .rs1D_o(rs1D), .rs2D_o(rs2D),
        .rd1E_o(rd1E), .rd2E_o(rd2E), .immExtE_o(immExtE),
        .pcE_o(pcE), .pcPlus4E_o(pcPlus4E),
        .rs1E_o(rs1E), .rs2E_o(rs2E), .rdE_o(rdE),
        .aluOpE_o(aluOpE), .aluSrcAE_o(aluSrcAE), .aluSrcBE_o(aluSrcBE),
        .branchE_o(branchE), .jumpE_o(jumpE), .regWriteE_o(regWriteE),
        .memWriteE_o(memWriteE), .memReadE_o(memReadE), .resultSrcE_o(resultSrcE)
    );

    regFile u_regFile (
        .clk(clk), .reset(reset), .regWrite_i(regWriteW),
        .rs1_i(rs1D), .rs2_i(rs2D), .rd_i(rdW), .wd_i(resultW),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    executeStage u_execute (
        .clk(clk), .reset(reset),
        .rd1E_i(rd1E), .rd2E_i(rd2E), .immExtE_i(immExtE),
        .pcE_i(pcE), .pcPlus4E_i(pcPlus4E), .rdE_i(rdE),
        .aluOpE_i(aluOpE), .aluSrcAE_i(aluSrcAE), .aluSrcBE_i(aluSrcBE),
        .branchE_i(branchE), .jumpE_i(jumpE), .regWriteE_i(regWriteE),
        .memWriteE_i(memWriteE), .memReadE_i(memReadE), .resultSrcE_i(resultSrcE),
        .forwardAE_i(forwardAE), .forwardBE_i(forwardBE), .resultW_i(resultW),
        .pcSrcE_o(pcSrcE), .pcTargetE_o(pcTargetE),
        .aluResultM_o(aluResultM), .writeDataM_o(writeDataM), .pcPlus4M_o(pcPlus4M),
        .rdM_o(rdM), .regWriteM_o(regWriteM), .memWriteM_o(memWriteM),
        .memReadM_o(memReadM), .resultSrcM_o(resultSrcM)
    );

    hazardUnit u_hazard (
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .resultSrcE_i(resultSrcE), .pcSrcE_i(pcSrcE),
        .regWriteM_i(regWriteM), .regWriteW_i(regWriteW),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE)
    );

    memWbStage u_memWb (
        .clk(clk), .reset(reset),
        .aluResultM_i(aluResultM), .readData_i(readData_i), .pcPlus4M_i(pcPlus4M),
        .rdM_i(rdM), .regWriteM_i(regWriteM), .resultSrcM_i(resultSrcM),
        .resultW_o(resultW), .rdW_o(rdW), .regWriteW_o(regWriteW)
    );

endmodule

// File: rvCore_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define RV_RESET_PC     32'h0000_0000
`define RV_INSTR_STEP   32'd4
`define RV_NUM_REGS     32

// halt loop counts once pcF stays put this many cycles
`define RV_HALT_HOLD    8
// give up on reaching the halt loop after this many cycles
`define RV_HALT_TIMEOUT 2000

`endif

// File: rvCtrlPkg.sv
package rvCtrlPkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } aluOp_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } immSrc_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2 // link value for jal
    } resultSrc_t;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_ITYPE  = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_RTYPE  = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwdSel_t;

endpackage

// File: rvTypesPkg.sv
package rvTypesPkg;

    // data, address or instruction word
    typedef logic [31:0] word_t;

    // register index, x0..x31
    typedef logic [4:0] regAddr_t;

    typedef logic [2:0] funct3_t;

endpackage

// File: tbRvCore.sv
`timescale 1ns/1ns
`include "rvCore_cfg.svh"

module tbRvCore;
    import rvTypesPkg::*;

    logic   clk;
    logic   reset;
    word_t  instrF;
    word_t  readData;
    word_t  pcF;
    word_t  dataAddr;
    word_t  writeData;
    logic   memWrite;
    logic   memRead;

    word_t  instrMem [256];
    word_t  dataMem [64];
    word_t  expAddr [$]; // stores predicted by the model, in order
    word_t  expData [$];
    word_t  expLoad [$]; // load addresses predicted by the model
    word_t  progPc;
    word_t  haltAddr;
    int     storeIdx;
    int     loadIdx;
    int     errCount;
    int     timeoutCount;
    integer seed;

    rvCore u_dut (
        .clk(clk), .reset(reset), .instrF_i(instrF), .readData_i(readData),
        .pcF_o(pcF), .dataAddr_o(dataAddr), .writeData_o(writeData),
        .memWrite_o(memWrite), .memRead_o(memRead)
    );

    // both memories answer in the same cycle
    assign instrF   = instrMem[pcF[9:2]];
    assign readData = dataMem[dataAddr[7:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every store leaving the core is compared with the next model entry
    always @(posedge clk) begin
        if (!reset && memWrite) begin
            assert (storeIdx < expAddr.size()) else begin
                errCount++;
                $display("ERROR: unexpected extra store of %h to address %h",
                         writeData, dataAddr);
            end
            if (storeIdx < expAddr.size()) begin
                assert (dataAddr == expAddr[storeIdx]) else begin
                    errCount++;
                    $display("MISMATCH dataAddr_o (store %0d): got %h, expected %h",
                             storeIdx, dataAddr, expAddr[storeIdx]);
                end
                assert (writeData == expData[storeIdx]) else begin
                    errCount++;
                    $display("MISMATCH writeData_o (store %0d): got %h, expected %h",
                             storeIdx, writeData, expData[storeIdx]);
                end
            end
            storeIdx++;
            dataMem[dataAddr[7:2]] <= writeData;
        end
    end

    // every load strobe is compared with the next model load address
    always @(posedge clk) begin
        if (!reset && memRead) begin
            assert (loadIdx < expLoad.size()) else begin
                errCount++;
                $display("ERROR: unexpected extra load from address %h", dataAddr);
            end
            if (loadIdx < expLoad.size()) begin
                assert (dataAddr == expLoad[loadIdx]) else begin
                    errCount++;
                    $display("MISMATCH dataAddr_o (load %0d): got %h, expected %h",
                             loadIdx, dataAddr, expLoad[loadIdx]);
                end
            end
            loadIdx++;
        end
    end

    task automatic place(word_t ins);
        instrMem[progPc[9:2]] = ins;
        progPc = progPc + 32'd4;
    endtask

    task automatic rType(logic [6:0] f7, int f3, int rd, int rs1, int rs2);
        place({f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011});
    endtask

    task automatic iType(int f3, int rd, int rs1, int imm);
        place({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011});
    endtask

    task automatic loadWord(int rd, int rs1, int imm);
        place({imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011});
    endtask

    task automatic storeWord(int rs2, int rs1, int imm);
        place({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011});
    endtask

    task automatic branchEq(int rs1, int rs2, int off);
        place({off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011});
    endtask

    task automatic jumpLink(int rd, int off);
        place({off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111});
    endtask

    task automatic loadUpper(int rd, int upper);
        place({upper[19:0], rd[4:0], 7'b0110111});
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = '0; // zero word runs as a bubble
        end
        progPc = `RV_RESET_PC;
        loadWord(1, 0, 0);
        loadWord(2, 0, 4);
        rType(7'h00, 0, 3, 1, 2);  // add x3, x1, x2 right behind its load
        storeWord(3, 0, 128);
        rType(7'h20, 0, 4, 3, 1);  // sub
        storeWord(4, 0, 132);
        rType(7'h00, 7, 5, 4, 3);  // and
        rType(7'h00, 6, 6, 5, 2);  // or
        rType(7'h00, 4, 7, 6, 5);  // xor, both operands forwarded
        storeWord(5, 0, 136);
        storeWord(6, 0, 140);
        storeWord(7, 0, 144);
        rType(7'h00, 2, 8, 1, 2);  // slt on random signed words
        storeWord(8, 0, 148);
        iType(0, 9, 1, -5);
        iType(7, 10, 9, 'h7F0);
        iType(6, 11, 10, -256);
        iType(4, 12, 11, 'h555);
        iType(2, 13, 12, -1);
        iType(2, 14, 1, 0);
        storeWord(9, 0, 152);
        storeWord(10, 0, 156);
        storeWord(11, 0, 160);
        storeWord(12, 0, 164);
        storeWord(13, 0, 168);
        storeWord(14, 0, 172);
        iType(0, 15, 0, -7);
        iType(0, 16, 0, 3);
        rType(7'h00, 2, 17, 15, 16);
        rType(7'h00, 2, 18, 16, 15);
        loadUpper(19, 'h80000);    // most negative word
        iType(0, 20, 0, 1);
        rType(7'h00, 2, 21, 19, 20); // difference overflows here
        storeWord(17, 0, 176);
        storeWord(18, 0, 180);
        storeWord(21, 0, 184);
        loadWord(22, 0, 8);
        iType(0, 23, 22, 100);     // load-use bubble
        storeWord(23, 0, 188);
        loadWord(26, 0, 12);
        storeWord(26, 0, 192);     // store data straight from a load
        branchEq(16, 16, 12);      // taken
        storeWord(16, 0, 196);
        storeWord(15, 0, 200);
        branchEq(15, 16, 8);       // not taken
        storeWord(15, 0, 204);
        jumpLink(24, 12);
        storeWord(15, 0, 208);
        storeWord(16, 0, 212);
        storeWord(24, 0, 216);     // link value
        loadUpper(25, 'h12345);
        iType(0, 25, 25, 'h678);
        storeWord(25, 0, 220);
        loadUpper(27, 'hABCDE);
        iType(0, 27, 27, -291);
        storeWord(27, 0, 224);
        iType(0, 0, 0, 55);        // x0 must stay zero
        storeWord(0, 0, 228);
        haltAddr = progPc;
        jumpLink(0, 0);
    endtask

    function automatic word_t aluRef(logic [2:0] f3, logic isSub, word_t a, word_t b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'hDEAD_BEEF;
        endcase
    endfunction

    // instruction-level model, one instruction per step, no pipeline
    task automatic runModel();
        word_t regs [32];
        word_t mem [64];
        word_t pc;
        word_t nextPc;
        word_t ins;
        word_t a;
        word_t b;
        word_t immI;
        word_t immS;
        word_t immB;
        word_t immJ;
        word_t addr;
        logic  halted;
        int    steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = dataMem[i];
        end
        pc = `RV_RESET_PC;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 1000) begin
            ins    = instrMem[pc[9:2]];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: regs[ins[11:7]] = aluRef(ins[14:12], ins[30], a, b);
                7'b0010011: regs[ins[11:7]] = aluRef(ins[14:12], 1'b0, a, immI);
                7'b0000011: begin
                    addr = a + immI;
                    regs[ins[11:7]] = mem[addr[7:2]];
                    expLoad.push_back(addr);
                end
                7'b0100011: begin
                    addr = a + immS;
                    mem[addr[7:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                7'b1100011: begin
                    if (a == b) begin
                        nextPc = pc + immB;
                    end
                end
                7'b1101111: begin
                    regs[ins[11:7]] = pc + 32'd4;
                    nextPc = pc + immJ;
                end
                7'b0110111: regs[ins[11:7]] = {ins[31:12], 12'b0};
                default: ;
            endcase
            regs[0] = '0;
            halted = (nextPc == pc); // jal to itself
            pc = nextPc;
            steps++;
        end
        assert (halted) else begin
            errCount++;
            $display("ERROR: reference model never reached the halt loop");
        end
    endtask

    task automatic checkIdle();
        assert (pcF == `RV_RESET_PC) else begin
            errCount++;
            $display("MISMATCH pcF_o: got %h, expected %h", pcF, `RV_RESET_PC);
        end
        assert (!memWrite) else begin
            errCount++;
            $display("MISMATCH memWrite_o: got %h, expected 0", memWrite);
        end
        assert (!memRead) else begin
            errCount++;
            $display("MISMATCH memRead_o: got %h, expected 0", memRead);
        end
    endtask

    // the halt jal refetches itself, so pcF walks haltAddr..haltAddr+8
    task automatic waitForHalt();
        int cycles;
        int holdCount;
        cycles = 0;
        holdCount = 0;
        while (holdCount < `RV_HALT_HOLD && cycles < `RV_HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (pcF >= haltAddr && pcF <= haltAddr + 32'd8) begin
                holdCount++;
            end else begin
                holdCount = 0;
            end
        end
        if (holdCount < `RV_HALT_HOLD) begin
            timeoutCount++;
            $display("ERROR: timed out after %0d cycles waiting for the halt loop", cycles);
        end
    endtask

    initial begin
        reset = 1'b1;
        errCount = 0;
        timeoutCount = 0;
        storeIdx = 0;
        loadIdx = 0;
        seed = 21276;
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);
        end
        for (int i = 0; i < 4; i++) begin
            dataMem[i] = $random(seed); // load operands
        end
        loadProgram();
        runModel();
        repeat (16) begin
            @(negedge clk);
            checkIdle();
        end
        reset = 1'b0;
        checkIdle();
        waitForHalt();
        assert (storeIdx == expAddr.size()) else begin
            errCount++;
            $display("ERROR: core made %0d stores, model expects %0d", storeIdx, expAddr.size());
        end
        assert (loadIdx == expLoad.size()) else begin
            errCount++;
            $display("ERROR: core made %0d loads, model expects %0d", loadIdx, expLoad.size());
        end
        $display("errors: %0d, timeouts: %0d, stores: %0d of %0d, loads: %0d of %0d",
                 errCount, timeoutCount, storeIdx, expAddr.size(), loadIdx, expLoad.size());
        if (errCount == 0 && timeoutCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
